// ==== verilog/mshr_params.svh ====
`ifndef MSHR_PARAMS_SVH
`define MSHR_PARAMS_SVH

// entry count, index width must track it
`define MSHR_ENTRY_NUM 8
`define MSHR_IDX_W     3

// cache line address and requester txn id
`define MSHR_ADDR_W    26
`define MSHR_TXNID_W   8

`endif

// ==== verilog/mshr_pkg.sv ====
`default_nettype none

`include "mshr_params.svh"

package mshr_pkg;

    typedef logic [`MSHR_IDX_W-1:0]     mshr_idx_t;
    typedef logic [`MSHR_ENTRY_NUM-1:0] mshr_vec_t;   // one bit per entry
    typedef logic [`MSHR_ADDR_W-1:0]    mshr_addr_t;
    typedef logic [`MSHR_TXNID_W-1:0]   mshr_txnid_t;

    // data RAM request type
    typedef enum logic {
        RAM_OP_LF_WRITE = 1'b0,
        RAM_OP_READ     = 1'b1
    } ram_op_t;

    // entry FSM
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_RSVD    = 3'd1,   // spare code
        ST_DS_REQ  = 3'd2,
        ST_WAIT_LF = 3'd3,
        ST_LF_WR   = 3'd4,
        ST_RD      = 3'd5,
        ST_WAIT_RD = 3'd6
    } mshr_state_t;

endpackage

`default_nettype wire

// ==== verilog/mshr_alloc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mshr_params.svh"

module mshr_alloc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_rdy,
    input  logic                release_vld,
    input  mshr_pkg::mshr_idx_t release_idx,
    output logic                alloc_vld,
    output mshr_pkg::mshr_idx_t alloc_idx,
    output logic                mshr_full
);

    import mshr_pkg::*;

    mshr_vec_t busy;
    mshr_vec_t free_vec;

    assign free_vec  = ~busy;
    assign alloc_vld = |free_vec;
    assign mshr_full = &busy;

    // lowest free entry wins
    always_comb begin
        alloc_idx = '0;
        for (int i = `MSHR_ENTRY_NUM - 1; i >= 0; i--) begin
            if (free_vec[i]) begin
                alloc_idx = mshr_idx_t'(i);
            end
        end
    end

    // set on tag pipe handshake, clear on release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (alloc_vld && alloc_rdy) begin
                busy[alloc_idx] <= 1'b1;
            end
            if (release_vld) begin
                busy[release_idx] <= 1'b0;   // never the index just taken
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mshr_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

module mshr_entry (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  update_en,
    input  mshr_pkg::mshr_addr_t  update_addr,
    input  mshr_pkg::mshr_txnid_t update_txnid,
    input  logic                  ds_gnt,
    input  logic                  lf_done,
    input  logic                  ram_gnt,
    input  logic                  rd_done,
    output logic                  ds_req,
    output logic                  ram_req,
    output mshr_pkg::ram_op_t     ram_op,
    output mshr_pkg::mshr_addr_t  addr,
    output mshr_pkg::mshr_txnid_t txnid,
    output logic                  release_en
);

    import mshr_pkg::*;

    mshr_state_t state;
    mshr_state_t state_nxt;

    // --------------------
    // miss flow
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (update_en) begin
                    state_nxt = ST_DS_REQ;
                end
            end
            ST_DS_REQ: begin
                if (ds_gnt) begin
                    state_nxt = ST_WAIT_LF;
                end
            end
            ST_WAIT_LF: begin
                if (lf_done) begin
                    state_nxt = ST_LF_WR;
                end
            end
            ST_LF_WR: begin
                if (ram_gnt) begin
                    state_nxt = ST_RD;
                end
            end
            ST_RD: begin
                if (ram_gnt) begin
                    state_nxt = ST_WAIT_RD;
                end
            end
            ST_WAIT_RD: begin
                if (rd_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;   // includes ST_RSVD
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            release_en <= 1'b0;
        end else begin
            state      <= state_nxt;
            release_en <= (state == ST_WAIT_RD) && rd_done;
        end
    end

    // --------------------
    // stored request
    always_ff @(posedge clk) begin
        if (update_en && (state == ST_IDLE)) begin
            addr  <= update_addr;
            txnid <= update_txnid;
        end
    end

    assign ds_req  = (state == ST_DS_REQ);
    assign ram_req = (state == ST_LF_WR) || (state == ST_RD);
    assign ram_op  = (state == ST_RD) ? RAM_OP_READ : RAM_OP_LF_WRITE;   // write first

endmodule

`default_nettype wire

// ==== verilog/mshr_entry_table.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mshr_params.svh"

module mshr_entry_table (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    update_en,
    input  mshr_pkg::mshr_idx_t                     update_idx,
    input  mshr_pkg::mshr_addr_t                    update_addr,
    input  mshr_pkg::mshr_txnid_t                   update_txnid,
    input  mshr_pkg::mshr_vec_t                     ds_gnt,
    input  logic                                    lf_done,
    input  mshr_pkg::mshr_idx_t                     lf_done_idx,
    input  mshr_pkg::mshr_vec_t                     ram_gnt,
    input  logic                                    rd_done,
    input  mshr_pkg::mshr_idx_t                     rd_done_idx,
    output mshr_pkg::mshr_vec_t                     ds_req,
    output mshr_pkg::mshr_vec_t                     ram_req,
    output logic [`MSHR_ENTRY_NUM*`MSHR_ADDR_W-1:0] ds_pld,
    output logic [`MSHR_ENTRY_NUM*($bits(mshr_pkg::ram_op_t)
                  + `MSHR_ADDR_W + `MSHR_TXNID_W)-1:0] ram_pld,
    output logic                                    release_vld,
    output mshr_pkg::mshr_idx_t                     release_idx
);

    import mshr_pkg::*;

    mshr_vec_t   v_update_en;
    mshr_vec_t   v_lf_done;
    mshr_vec_t   v_rd_done;
    mshr_vec_t   v_release;
    ram_op_t     entry_op    [`MSHR_ENTRY_NUM];
    mshr_addr_t  entry_addr  [`MSHR_ENTRY_NUM];
    mshr_txnid_t entry_txnid [`MSHR_ENTRY_NUM];

    logic [`MSHR_ENTRY_NUM-1:0][`MSHR_ADDR_W-1:0] ds_pld_arr;
    logic [`MSHR_ENTRY_NUM-1:0][$bits(ram_op_t)+`MSHR_ADDR_W+`MSHR_TXNID_W-1:0] ram_pld_arr;

    for (genvar i = 0; i < `MSHR_ENTRY_NUM; i++) begin : g_entry
        // index to per-entry strobe
        assign v_update_en[i] = update_en && (update_idx == mshr_idx_t'(i));
        assign v_lf_done[i]   = lf_done && (lf_done_idx == mshr_idx_t'(i));
        assign v_rd_done[i]   = rd_done && (rd_done_idx == mshr_idx_t'(i));

        mshr_entry u_entry (
            .clk          (clk),
            .rst_n        (rst_n),
            .update_en    (v_update_en[i]),
            .update_addr  (update_addr),
            .update_txnid (update_txnid),
            .ds_gnt       (ds_gnt[i]),
            .lf_done      (v_lf_done[i]),
            .ram_gnt      (ram_gnt[i]),
            .rd_done      (v_rd_done[i]),
            .ds_req       (ds_req[i]),
            .ram_req      (ram_req[i]),
            .ram_op       (entry_op[i]),
            .addr         (entry_addr[i]),
            .txnid        (entry_txnid[i]),
            .release_en   (v_release[i])
        );

        assign ds_pld_arr[i]  = entry_addr[i];
        assign ram_pld_arr[i] = {entry_op[i], entry_addr[i], entry_txnid[i]};   // op on top
    end

    assign ds_pld  = ds_pld_arr;
    assign ram_pld = ram_pld_arr;

    // one rd_done per cycle, so release is one-hot
    assign release_vld = |v_release;

    always_comb begin
        release_idx = '0;
        for (int i = 0; i < `MSHR_ENTRY_NUM; i++) begin
            if (v_release[i]) begin
                release_idx = release_idx | mshr_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mshr_rr_arb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mshr_rr_arb #(
    parameter  int REQ_NUM = 8,
    parameter  int PLD_W   = 26,
    localparam int IDX_W   = (REQ_NUM > 1) ? $clog2(REQ_NUM) : 1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [REQ_NUM-1:0]       req,
    input  logic [REQ_NUM*PLD_W-1:0] pld,
    input  logic                     rdy,
    output logic [REQ_NUM-1:0]       gnt,
    output logic                     vld,
    output logic [IDX_W-1:0]         gnt_idx,
    output logic [PLD_W-1:0]         out_pld
);

    logic [IDX_W-1:0] ptr;        // highest priority slot
    logic [IDX_W-1:0] rr_idx;
    logic [IDX_W-1:0] lock_idx;
    logic             lock_vld;
    logic             hsk;

    // first requester at or after ptr
    always_comb begin
        int   cand;
        logic found;
        rr_idx = ptr;
        found  = 1'b0;
        for (int k = 0; k < REQ_NUM; k++) begin
            cand = (int'(ptr) + k) % REQ_NUM;
            if (!found && req[cand]) begin
                rr_idx = IDX_W'(cand);
                found  = 1'b1;
            end
        end
    end

    assign vld     = |req;
    assign gnt_idx = lock_vld ? lock_idx : rr_idx;   // stalled winner keeps the port
    assign out_pld = pld[gnt_idx*PLD_W +: PLD_W];
    assign hsk     = vld && rdy;

    always_comb begin
        gnt = '0;
        if (hsk) begin
            gnt[gnt_idx] = 1'b1;
        end
    end

    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            lock_vld <= 1'b0;
            lock_idx <= '0;
        end else begin
            lock_vld <= vld && !rdy;
            lock_idx <= gnt_idx;
            if (hsk) begin
                ptr <= (gnt_idx == IDX_W'(REQ_NUM - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vec_mshr.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mshr_params.svh"

module vec_mshr (
    input  logic                  clk,
    input  logic                  rst_n,
    // tag pipe
    output logic                  alloc_vld,
    output mshr_pkg::mshr_idx_t   alloc_idx,
    input  logic                  alloc_rdy,
    input  logic                  update_en,
    input  mshr_pkg::mshr_idx_t   update_idx,
    input  mshr_pkg::mshr_addr_t  update_addr,
    input  mshr_pkg::mshr_txnid_t update_txnid,
    // downstream
    output logic                  ds_req_vld,
    input  logic                  ds_req_rdy,
    output mshr_pkg::mshr_idx_t   ds_req_idx,
    output mshr_pkg::mshr_addr_t  ds_req_addr,
    input  logic                  lf_done,
    input  mshr_pkg::mshr_idx_t   lf_done_idx,
    // data RAM
    output logic                  ram_req_vld,
    input  logic                  ram_req_rdy,
    output mshr_pkg::ram_op_t     ram_req_op,
    output mshr_pkg::mshr_idx_t   ram_req_idx,
    output mshr_pkg::mshr_addr_t  ram_req_addr,
    output mshr_pkg::mshr_txnid_t ram_req_txnid,
    input  logic                  rd_done,
    input  mshr_pkg::mshr_idx_t   rd_done_idx,
    // status
    output logic                  release_vld,
    output mshr_pkg::mshr_idx_t   release_idx,
    output logic                  mshr_full
);

    import mshr_pkg::*;

    mshr_vec_t ds_req_vec;
    mshr_vec_t ds_gnt_vec;
    mshr_vec_t ram_req_vec;
    mshr_vec_t ram_gnt_vec;

    logic [`MSHR_ENTRY_NUM*`MSHR_ADDR_W-1:0] ds_pld;
    logic [`MSHR_ENTRY_NUM*($bits(ram_op_t)+`MSHR_ADDR_W+`MSHR_TXNID_W)-1:0] ram_pld;
    logic [$bits(ram_op_t)+`MSHR_ADDR_W+`MSHR_TXNID_W-1:0] ram_out_pld;

    mshr_alloc u_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_rdy   (alloc_rdy),
        .release_vld (release_vld),
        .release_idx (release_idx),
        .alloc_vld   (alloc_vld),
        .alloc_idx   (alloc_idx),
        .mshr_full   (mshr_full)
    );

    mshr_entry_table u_entry_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .update_en    (update_en),
        .update_idx   (update_idx),
        .update_addr  (update_addr),
        .update_txnid (update_txnid),
        .ds_gnt       (ds_gnt_vec),
        .lf_done      (lf_done),
        .lf_done_idx  (lf_done_idx),
        .ram_gnt      (ram_gnt_vec),
        .rd_done      (rd_done),
        .rd_done_idx  (rd_done_idx),
        .ds_req       (ds_req_vec),
        .ram_req      (ram_req_vec),
        .ds_pld       (ds_pld),
        .ram_pld      (ram_pld),
        .release_vld  (release_vld),
        .release_idx  (release_idx)
    );

    // --------------------
    // miss request to downstream
    mshr_rr_arb #(
        .REQ_NUM (`MSHR_ENTRY_NUM),
        .PLD_W   (`MSHR_ADDR_W)
    ) u_ds_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (ds_req_vec),
        .pld     (ds_pld),
        .rdy     (ds_req_rdy),
        .gnt     (ds_gnt_vec),
        .vld     (ds_req_vld),
        .gnt_idx (ds_req_idx),
        .out_pld (ds_req_addr)
    );

    // linefill writes and reads share the RAM port
    mshr_rr_arb #(
        .REQ_NUM (`MSHR_ENTRY_NUM),
        .PLD_W   ($bits(ram_op_t) + `MSHR_ADDR_W + `MSHR_TXNID_W)
    ) u_ram_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (ram_req_vec),
        .pld     (ram_pld),
        .rdy     (ram_req_rdy),
        .gnt     (ram_gnt_vec),
        .vld     (ram_req_vld),
        .gnt_idx (ram_req_idx),
        .out_pld (ram_out_pld)
    );

    assign ram_req_txnid = ram_out_pld[`MSHR_TXNID_W-1:0];
    assign ram_req_addr  = ram_out_pld[`MSHR_TXNID_W +: `MSHR_ADDR_W];
    assign ram_req_op    = ram_op_t'(ram_out_pld[`MSHR_TXNID_W+`MSHR_ADDR_W +: $bits(ram_op_t)]);

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;   // 50% duty
    end

endmodule

`default_nettype wire

// ==== tb/mshr_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mshr_params.svh"

module mshr_assert (
    input logic                  clk, rst_n,
    input logic                  alloc_vld, alloc_rdy, update_en, mshr_full,
    input logic                  ds_req_vld, ds_req_rdy, ram_req_vld, ram_req_rdy,
    input logic                  lf_done, rd_done, release_vld,
    input mshr_pkg::mshr_idx_t   alloc_idx, update_idx, ds_req_idx, ram_req_idx,
    input mshr_pkg::mshr_idx_t   lf_done_idx, rd_done_idx, release_idx,
    input mshr_pkg::mshr_addr_t  update_addr, ds_req_addr, ram_req_addr,
    input mshr_pkg::mshr_txnid_t update_txnid, ram_req_txnid,
    input mshr_pkg::ram_op_t     ram_req_op
);

    import mshr_pkg::*;

    int          fail_cnt = 0;
    mshr_vec_t   busy_sh;        // taken, not yet released
    mshr_vec_t   lf_seen;
    mshr_vec_t   wr_seen;
    mshr_addr_t  addr_sh  [`MSHR_ENTRY_NUM];
    mshr_txnid_t txnid_sh [`MSHR_ENTRY_NUM];
    logic        ram_hsk;

    assign ram_hsk = ram_req_vld && ram_req_rdy;

    task automatic count_fail(input string msg);
        $error("FAIL %0t %s", $time, msg);
        fail_cnt++;
    endtask

    // --------------------
    // shadow state from the ports
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_sh <= '0;
            lf_seen <= '0;
            wr_seen <= '0;
        end else begin
            if (alloc_vld && alloc_rdy) busy_sh[alloc_idx] <= 1'b1;
            if (release_vld) busy_sh[release_idx] <= 1'b0;
            if (update_en) begin
                lf_seen[update_idx] <= 1'b0;   // new miss in this entry
                wr_seen[update_idx] <= 1'b0;
            end
            if (lf_done) lf_seen[lf_done_idx] <= 1'b1;
            if (ram_hsk && ram_req_op == RAM_OP_LF_WRITE) wr_seen[ram_req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_en) begin
            addr_sh[update_idx]  <= update_addr;
            txnid_sh[update_idx] <= update_txnid;
        end
    end

    // --------------------
    a_alloc_free : assert property (@(posedge clk) disable iff (!rst_n)
        alloc_vld |-> !busy_sh[alloc_idx])
        else count_fail("alloc_idx offers an entry that is still busy");
    a_ds_addr : assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && ds_req_rdy |-> ds_req_addr == addr_sh[ds_req_idx])
        else count_fail("ds_req_addr differs from the update address");
    a_ds_hold : assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_req_rdy |=> $stable({ds_req_idx, ds_req_addr}))
        else count_fail("ds_req payload moved under back-pressure");
    a_ram_hold : assert property (@(posedge clk) disable iff (!rst_n)
        ram_req_vld && !ram_req_rdy
        |=> $stable({ram_req_op, ram_req_idx, ram_req_addr, ram_req_txnid}))
        else count_fail("ram_req payload moved under back-pressure");
    a_ram_order : assert property (@(posedge clk) disable iff (!rst_n)
        ram_hsk |-> ((ram_req_op == RAM_OP_LF_WRITE) ? lf_seen[ram_req_idx]
                                                     : wr_seen[ram_req_idx]))
        else count_fail("RAM op issued out of miss order");
    a_ram_txnid : assert property (@(posedge clk) disable iff (!rst_n)
        ram_hsk |-> ram_req_txnid == txnid_sh[ram_req_idx])
        else count_fail("ram_req_txnid differs from the update txn id");
    a_ram_addr : assert property (@(posedge clk) disable iff (!rst_n)
        ram_hsk |-> ram_req_addr == addr_sh[ram_req_idx])
        else count_fail("ram_req_addr differs from the update address");
    a_release : assert property (@(posedge clk) disable iff (!rst_n)
        release_vld == $past(rd_done)
        && (!release_vld || release_idx == $past(rd_done_idx)))
        else count_fail("release does not follow rd_done by one cycle");
    a_full : assert property (@(posedge clk) disable iff (!rst_n)
        mshr_full == (&busy_sh) && alloc_vld == !(&busy_sh))
        else count_fail("mshr_full or alloc_vld disagrees with busy entries");

endmodule

`default_nettype wire

// ==== tb/tb_vec_mshr.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mshr_params.svh"

module tb_vec_mshr;

    import mshr_pkg::*;

    localparam int MISS_NUM = `MSHR_ENTRY_NUM + 40;   // fill, then random misses
    localparam int TIMEOUT  = 1000;

    logic        clk, rst_n;
    logic        alloc_vld, alloc_rdy, update_en, mshr_full;
    logic        ds_req_vld, ds_req_rdy, ram_req_vld, ram_req_rdy;
    logic        lf_done, rd_done, release_vld;
    mshr_idx_t   alloc_idx, update_idx, ds_req_idx, ram_req_idx;
    mshr_idx_t   lf_done_idx, rd_done_idx, release_idx;
    mshr_addr_t  update_addr, ds_req_addr, ram_req_addr;
    mshr_txnid_t update_txnid, ram_req_txnid;
    ram_op_t     ram_req_op;

    int          seed        = 62;
    int          err_cnt     = 0;
    int          release_cnt = 0;
    int          lf_wait     = 0;
    int          rd_wait     = 0;
    bit          answer_en   = 1'b0;
    bit          run_ok      = 1'b1;
    mshr_idx_t   lf_q [$];
    mshr_idx_t   rd_q [$];
    mshr_addr_t  miss_addr  [MISS_NUM];
    mshr_txnid_t miss_txnid [MISS_NUM];

    tb_clk_gen #(.PERIOD(10)) u_clk_gen (.clk(clk));

    vec_mshr u_vec_mshr (.*);

    bind vec_mshr mshr_assert u_mshr_assert (.*);

    // --------------------
    // downstream and data RAM side
    always @(posedge clk) begin
        if (rst_n) begin
            ds_req_rdy  <= ($random(seed) & 3) != 0;
            ram_req_rdy <= ($random(seed) & 3) != 0;
            lf_done     <= 1'b0;
            rd_done     <= 1'b0;
            if (release_vld) release_cnt++;
            if (ds_req_vld && ds_req_rdy) lf_q.push_back(ds_req_idx);
            if (ram_req_vld && ram_req_rdy && ram_req_op == RAM_OP_READ) begin
                rd_q.push_back(ram_req_idx);
            end
            if (lf_wait > 0) begin
                lf_wait--;
            end else if (answer_en && lf_q.size() > 0) begin
                lf_done     <= 1'b1;
                lf_done_idx <= lf_q.pop_front();
                lf_wait     = $random(seed) & 3;
            end
            if (rd_wait > 0) begin
                rd_wait--;
            end else if (answer_en && rd_q.size() > 0) begin
                rd_done     <= 1'b1;
                rd_done_idx <= rd_q.pop_front();
                rd_wait     = $random(seed) & 3;
            end
        end
    end

    // tag pipe: take the offered index, update it on the next cycle
    task automatic issue_miss(input int n);
        int wait_cyc;
        wait_cyc = 0;
        alloc_rdy <= 1'b1;
        do begin
            @(posedge clk);
            wait_cyc++;
        end while (!alloc_vld && wait_cyc < TIMEOUT);
        alloc_rdy <= 1'b0;
        if (!alloc_vld) begin
            $display("timeout: no free entry was offered for miss %0d", n);
            err_cnt++;
            run_ok = 1'b0;
        end else begin
            update_en    <= 1'b1;
            update_idx   <= alloc_idx;
            update_addr  <= miss_addr[n];
            update_txnid <= miss_txnid[n];
            @(posedge clk);
            update_en <= 1'b0;
        end
    endtask

    initial begin
        int wait_cyc;
        rst_n        = 1'b0;
        alloc_rdy    = 1'b0;
        update_en    = 1'b0;
        update_idx   = '0;
        update_addr  = '0;
        update_txnid = '0;
        ds_req_rdy   = 1'b0;
        ram_req_rdy  = 1'b0;
        lf_done      = 1'b0;
        lf_done_idx  = '0;
        rd_done      = 1'b0;
        rd_done_idx  = '0;
        for (int i = 0; i < MISS_NUM; i++) begin
            miss_addr[i]  = mshr_addr_t'($random(seed));
            miss_txnid[i] = mshr_txnid_t'($random(seed));
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < MISS_NUM && run_ok; i++) begin
            if (i == `MSHR_ENTRY_NUM) answer_en <= 1'b1;   // all entries busy here
            issue_miss(i);
        end
        wait_cyc = 0;
        while (run_ok && release_cnt < MISS_NUM && wait_cyc < TIMEOUT) begin
            @(posedge clk);
            wait_cyc++;
        end
        if (run_ok && release_cnt < MISS_NUM) begin
            $display("timeout: only %0d of %0d misses were released", release_cnt, MISS_NUM);
            err_cnt++;
        end
        repeat (2) @(posedge clk);
        $display("errors: testbench %0d, assertions %0d", err_cnt,
                 u_vec_mshr.u_mshr_assert.fail_cnt);
        if (err_cnt == 0 && u_vec_mshr.u_mshr_assert.fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/mshr_pkg.sv
verilog/mshr_alloc.sv
verilog/mshr_entry.sv
verilog/mshr_entry_table.sv
verilog/mshr_rr_arb.sv
verilog/vec_mshr.sv
tb/tb_clk_gen.sv
tb/mshr_assert.sv
tb/tb_vec_mshr.sv
